// ==== bpm_event_proc.f ====
+incdir+testbench
src/bpm_pkg.sv
src/event_sequencer.sv
src/channel_power.sv
src/packet_builder.sv
src/slow_fifo.sv
src/bpm_event_proc.sv
testbench/tb_bpm_event_proc.sv

// ==== testbench/bpm_model.svh ====
`ifndef BPM_MODEL_SVH
`define BPM_MODEL_SVH

// reference model of the event path for the testbench module

word_t            exp_q [$];     // packet words the fifo still owes us
logic             m_open;        // event window open
logic             m_busy;        // window as the DUT holds it after the last edge
int               m_left;        // samples still to take
logic             m_first;       // next accepted sample restarts sums
logic [15:0]      m_count;       // events finished since reset
logic [ACC_W-1:0] m_acc  [N_CH]; // sum of squares per channel
int               m_peak [N_CH];
logic             m_ovf  [N_CH];

function automatic adc_sample_t chan_of(input adc_quad_t q, input int ch);
	case (ch)
		0:       return q.a;
		1:       return q.b;
		2:       return q.c;
		default: return q.d;
	endcase
endfunction

function automatic void model_reset();
	exp_q.delete();
	m_open  = 1'b0;
	m_busy  = 1'b0;
	m_left  = 0;
	m_first = 1'b0;
	m_count = '0;
endfunction

// count the finished event and queue its packet if the fifo has room
function automatic void model_close();
	m_count++; // dropped packets still count
	if (exp_q.size() < FIFO_HALF) begin
		exp_q.push_back(PID);
		exp_q.push_back({m_ovf[0], m_ovf[1], m_ovf[2], m_ovf[3], 12'h000, m_count});
		for (int ch = 0; ch < N_CH; ch++)
			exp_q.push_back(word_t'(m_acc[ch] >> POWER_SHIFT)); // low 32 bits
		exp_q.push_back({16'(m_peak[0]), 16'(m_peak[1])});
		exp_q.push_back({16'(m_peak[2]), 16'(m_peak[3])});
	end
endfunction

// one cycle of inputs as the DUT will see them
function automatic void model_step(input logic st, input logic vld, input adc_quad_t q,
                                   input logic [EVT_LEN_W-1:0] len);
	int x;
	m_busy = m_open; // window after the edge just taken
	if (!m_open) begin
		if (st) begin // start only counts while idle
			m_open  = 1'b1;
			m_first = 1'b1;
			m_left  = (int'(len) < MIN_EVT_LEN) ? MIN_EVT_LEN : int'(len);
		end
	end else if (vld) begin
		for (int ch = 0; ch < N_CH; ch++) begin
			x = int'(chan_of(q, ch)); // sign extended
			if (m_first) begin
				m_acc[ch]  = '0;
				m_peak[ch] = 0;
				m_ovf[ch]  = 1'b0;
			end
			m_acc[ch] += ACC_W'(longint'(x) * longint'(x));
			if ((x < 0 ? -x : x) > m_peak[ch])
				m_peak[ch] = (x < 0) ? -x : x;
			if (x == 32767 || x == -32768)
				m_ovf[ch] = 1'b1; // full scale either way
		end
		m_first = 1'b0;
		m_left--;
		if (m_left == 0) begin
			m_open = 1'b0;
			model_close();
		end
	end
endfunction

`endif

// ==== testbench/tb_bpm_event_proc.sv ====
`timescale 1ns/1ns

module tb_bpm_event_proc
	import bpm_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 5;
	localparam int MAX_LEN    = 24;  // longest random evt_len
	localparam int RESULT_LAT = 3;   // last sample to result
	localparam int N_RUN_A    = 40;  // events before the mid-run reset
	localparam int N_RUN_B    = 20;  // events after it
	localparam int N_EVENTS   = N_RUN_A + N_RUN_B + 4;
	localparam int EVT_CYC    = 4 * MAX_LEN + 24; // valid rate 3/4 plus the widest gap
	localparam int DRAIN_CYC  = RESULT_LAT + PACKET_LEN + 2 * FIFO_DEPTH + 8;
	localparam int TIMEOUT_CYC = N_EVENTS * EVT_CYC + 4 * DRAIN_CYC + 3 * (RST_CYCLES + 2);

	logic                 clk = 1'b0;
	logic                 RST_EVENT_NO;
	logic                 start;
	logic                 sample_valid;
	adc_quad_t            sample;
	logic [EVT_LEN_W-1:0] evt_len;
	logic                 fifo_rd;
	word_t                fifo_dout;
	fifo_count_t          fifo_words;
	logic                 busy;
	logic                 rd_enable = 1'b0; // reader on or off

	`include "bpm_model.svh"

	bpm_event_proc UUT (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////
	task automatic fail_run();
		$display("Done: errors found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input word_t got);
		word_t exp;
		if (exp_q.size() == 0) begin
			$display("FIFO gave out a word at %0t with no packet word expected", $time);
			fail_run();
		end else begin
			exp = exp_q.pop_front();
			if (got !== exp) begin
				$display("MISMATCH at %0t: fifo word %h, expected %h", $time, got, exp);
				fail_run();
			end
		end
	endtask

	task automatic check_words(input fifo_count_t got, input fifo_count_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: fifo_words %0d, expected %0d", $time, got, exp);
			fail_run();
		end
	endtask

	task automatic check_busy(input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: busy %b, expected %b", $time, got, exp);
			fail_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////
	function automatic adc_sample_t rand_sample();
		int r;
		r = $urandom % 16;
		if (r == 0)
			return 16'sh7fff; // forced full scale
		else if (r == 1)
			return 16'sh8000;
		else
			return adc_sample_t'($urandom);
	endfunction

	function automatic adc_quad_t rand_quad();
		adc_quad_t q;
		q.a = rand_sample();
		q.b = rand_sample();
		q.c = rand_sample();
		q.d = rand_sample();
		return q;
	endfunction

	function automatic logic [EVT_LEN_W-1:0] rand_len();
		if ($urandom % 4 == 0)
			return EVT_LEN_W'($urandom % MIN_EVT_LEN); // short ones get stretched to 8
		else
			return EVT_LEN_W'(MIN_EVT_LEN + $urandom % (MAX_LEN - MIN_EVT_LEN + 1));
	endfunction

	task automatic drive_cycle(input logic st, input logic vld, input adc_quad_t q,
	                           input logic [EVT_LEN_W-1:0] len);
		@(negedge clk);
		check_busy(busy, m_busy); // window after the edge before
		@(posedge clk);
		start        <= st;
		sample_valid <= vld;
		sample       <= q;
		evt_len      <= len;
		model_step(st, vld, q, len); // DUT sees these on the next edge
	endtask

	// start pulse and samples with stray starts followed by an idle gap
	task automatic run_event(input int gap_min);
		int gap;
		gap = gap_min + $urandom % 8;
		drive_cycle(1'b1, 1'($urandom), rand_quad(), rand_len());
		while (m_open)
			drive_cycle(($urandom % 8) == 0, ($urandom % 4) != 0, rand_quad(), rand_len());
		repeat (gap)
			drive_cycle(1'b0, 1'($urandom), rand_quad(), rand_len()); // stray valids
	endtask

	task automatic apply_reset();
		@(posedge clk);
		RST_EVENT_NO <= 1'b1;
		start        <= 1'b0;
		sample_valid <= 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		RST_EVENT_NO <= 1'b0;
		model_reset();
		@(negedge clk);
		check_words(fifo_words, '0); // empty after reset
	endtask

	// wait out the last result and its packet write
	task automatic settle();
		while (busy) @(negedge clk);
		repeat (RESULT_LAT + PACKET_LEN + 1) @(negedge clk);
	endtask

	task automatic drain_fifo();
		rd_enable = 1'b1;
		while (exp_q.size() != 0) @(negedge clk);
		@(negedge clk);
		check_words(fifo_words, '0);
	endtask

	// reader takes one word every two cycles while allowed
	always begin
		@(negedge clk);
		while (rd_enable && fifo_words != '0) begin
			@(posedge clk);
			fifo_rd <= 1'b1;
			@(posedge clk);
			fifo_rd <= 1'b0;
			@(negedge clk);
			check_word(fifo_dout); // registered read port
		end
	end

	initial begin
		#(TIMEOUT_CYC * CLK_PERIOD);
		$display("watchdog: the run took longer than its time budget");
		fail_run();
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		void'($urandom(32'hea68));
		RST_EVENT_NO = 1'b1;
		start        = 1'b0;
		sample_valid = 1'b0;
		sample       = '0;
		evt_len      = '0;
		fifo_rd      = 1'b0;
		apply_reset();

		rd_enable = 1'b1; // random events read as they come
		repeat (N_RUN_A) run_event(14);
		settle();
		drain_fifo();

		rd_enable = 1'b0; // reader stopped so the third packet finds no room
		repeat (3) run_event(4);
		settle();
		check_words(fifo_words, fifo_count_t'(exp_q.size()));
		drain_fifo();
		run_event(14); // its count skips the dropped one
		settle();
		drain_fifo();

		rd_enable = 1'b0;
		apply_reset(); // counter restarts at 1
		rd_enable = 1'b1;
		repeat (N_RUN_B) run_event(14);
		settle();
		drain_fifo();

		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== src/bpm_event_proc.sv ====
`timescale 1ns/1ns

module bpm_event_proc
	import bpm_pkg::*;
(
	input  logic                 clk,
	input  logic                 RST_EVENT_NO,
	input  logic                 start,
	input  logic                 sample_valid,
	input  adc_quad_t            sample,
	input  logic [EVT_LEN_W-1:0] evt_len,
	input  logic                 fifo_rd,
	output word_t                fifo_dout,
	output fifo_count_t          fifo_words,
	output logic                 busy
);

	beat_t           beat;
	chan_result_t    results [N_CH];
	logic [N_CH-1:0] result_rdy; // all four coincide, builder uses ch 0
	logic            wr_en;
	word_t           wr_data;

	event_sequencer u_seq (
		.clk          (clk),
		.RST_EVENT_NO (RST_EVENT_NO),
		.start        (start),
		.sample_valid (sample_valid),
		.sample       (sample),
		.evt_len      (evt_len),
		.beat         (beat),
		.busy         (busy)
	);

	//////////////////////////////////////////////////////////////////////
	// channel processors a..d
	//////////////////////////////////////////////////////////////////////
	for (genvar i = 0; i < N_CH; i++) begin : g_ch
		channel_power u_ch (
			.clk          (clk),
			.RST_EVENT_NO (RST_EVENT_NO),
			.beat_valid   (beat.valid),
			.beat_first   (beat.first),
			.beat_last    (beat.last),
			.sample       (beat.data[i*ADC_W +: ADC_W]), // index 0 = channel a
			.result       (results[i]),
			.result_rdy   (result_rdy[i])
		);
	end

	packet_builder u_bld (
		.clk          (clk),
		.RST_EVENT_NO (RST_EVENT_NO),
		.results      (results),
		.result_rdy   (result_rdy[0]),
		.fifo_words   (fifo_words),
		.wr_en        (wr_en),
		.wr_data      (wr_data)
	);

	slow_fifo u_fifo (
		.clk          (clk),
		.RST_EVENT_NO (RST_EVENT_NO),
		.wr_en        (wr_en),
		.wr_data      (wr_data),
		.rd_en        (fifo_rd),
		.rd_data      (fifo_dout),
		.words        (fifo_words)
	);

endmodule

// ==== src/slow_fifo.sv ====
`timescale 1ns/1ns

module slow_fifo
	import bpm_pkg::*;
(
	input  logic        clk,
	input  logic        RST_EVENT_NO,
	input  logic        wr_en,
	input  word_t       wr_data,
	input  logic        rd_en,
	output word_t       rd_data,
	output fifo_count_t words
);

	word_t                 mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr; // wraps at depth
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic                  full;
	logic                  empty;
	logic                  do_wr;
	logic                  do_rd;

	assign full  = (words == fifo_count_t'(FIFO_DEPTH));
	assign empty = (words == '0);
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty; // read on empty ignored

	// storage
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	//////////////////////////////////////////////////////////////////////
	// pointers, count, registered read port
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			words   <= '0;
			rd_data <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) begin
				rd_ptr  <= rd_ptr + 1'b1;
				rd_data <= mem[rd_ptr]; // valid next cycle
			end
			case ({do_wr, do_rd})
				2'b10:   words <= words + 1'b1;
				2'b01:   words <= words - 1'b1;
				default: words <= words; // both or neither
			endcase
		end
	end

	// builder's half-full check must keep us from ever filling
	a_no_wr_full: assert property (@(posedge clk) disable iff (RST_EVENT_NO)
		wr_en |-> !full);

endmodule

// ==== src/packet_builder.sv ====
`timescale 1ns/1ns

module packet_builder
	import bpm_pkg::*;
(
	input  logic         clk,
	input  logic         RST_EVENT_NO,
	input  chan_result_t results [N_CH],
	input  logic         result_rdy,
	input  fifo_count_t  fifo_words,
	output logic         wr_en,
	output word_t        wr_data
);

	pkt_word_e        state;           // slot written this cycle
	chan_result_t     held [N_CH];     // results of the event being packed
	logic [CNT_W-1:0] evt_cnt;         // events since reset
	logic             room;
	logic [N_CH-1:0]  ovf_bits;

	assign room     = fifo_words < fifo_count_t'(FIFO_HALF); // whole packet fits
	assign ovf_bits = {held[0].overflow, held[1].overflow,
	                   held[2].overflow, held[3].overflow}; // a in msb

	//////////////////////////////////////////////////////////////////////
	// latch, count, step through slots
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			state   <= PKT_IDLE;
			evt_cnt <= '0;
			held    <= '{default: '0};
		end else if (state == PKT_IDLE) begin
			if (result_rdy) begin
				held    <= results;
				evt_cnt <= evt_cnt + 1'b1; // counts dropped packets too
				if (room)
					state <= PKT_PID;
			end
		end else if (state == PKT_PEAK_CD) begin
			state <= PKT_IDLE; // 8th word out
		end else begin
			state <= pkt_word_e'(state + 1'b1);
		end
	end

	// write port, one word per cycle
	assign wr_en = (state != PKT_IDLE);

	always_comb begin
		case (state)
			PKT_PID:     wr_data = PID;
			PKT_STATUS:  wr_data = {ovf_bits, {(CNT_W-N_CH){1'b0}}, evt_cnt};
			PKT_PWR_A:   wr_data = held[0].power;
			PKT_PWR_B:   wr_data = held[1].power;
			PKT_PWR_C:   wr_data = held[2].power;
			PKT_PWR_D:   wr_data = held[3].power;
			PKT_PEAK_AB: wr_data = {held[0].peak, held[1].peak};
			PKT_PEAK_CD: wr_data = {held[2].peak, held[3].peak};
			default:     wr_data = '0;
		endcase
	end

	// minimum event length keeps results apart from packets
	a_idle_on_rdy: assert property (@(posedge clk) disable iff (RST_EVENT_NO)
		result_rdy |-> state == PKT_IDLE);

endmodule

// ==== src/channel_power.sv ====
`timescale 1ns/1ns

module channel_power
	import bpm_pkg::*;
(
	input  logic         clk,
	input  logic         RST_EVENT_NO,
	input  logic         beat_valid,
	input  logic         beat_first,
	input  logic         beat_last,
	input  adc_sample_t  sample,
	output chan_result_t result,
	output logic         result_rdy
);

	logic [2*ADC_W-1:0] sq;         // x*x, never negative
	adc_mag_t           mag;
	logic               full_scale;

	// stage one
	logic               s1_valid;
	logic               s1_first;
	logic               s1_last;
	logic               s1_ovf;
	logic [2*ADC_W-1:0] s1_sq;
	adc_mag_t           s1_mag;

	// stage two
	logic [ACC_W-1:0]   acc;
	logic [ACC_W-1:0]   acc_next;
	adc_mag_t           peak;
	adc_mag_t           peak_next;
	logic               ovf;
	logic               ovf_next;

	assign sq         = sample * sample; // signed operands, 32-bit context
	assign mag        = sample[ADC_W-1] ? adc_mag_t'(-sample) : adc_mag_t'(sample);
	assign full_scale = (sample == ADC_MAX) || (sample == ADC_MIN);

	//////////////////////////////////////////////////////////////////////
	// stage one, square and magnitude
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			s1_valid <= 1'b0;
			s1_first <= 1'b0;
			s1_last  <= 1'b0;
			s1_ovf   <= 1'b0;
			s1_sq    <= '0;
			s1_mag   <= '0;
		end else begin
			s1_valid <= beat_valid;
			s1_first <= beat_valid && beat_first;
			s1_last  <= beat_valid && beat_last;
			s1_ovf   <= full_scale;
			s1_sq    <= sq;
			s1_mag   <= mag;
		end
	end

	// first beat restarts, later beats fold in
	always_comb begin
		acc_next  = s1_first ? ACC_W'(s1_sq) : acc + ACC_W'(s1_sq);
		peak_next = (s1_first || s1_mag > peak) ? s1_mag : peak;
		ovf_next  = s1_ovf || (ovf && !s1_first);
	end

	//////////////////////////////////////////////////////////////////////
	// stage two, accumulate and emit
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			acc        <= '0;
			peak       <= '0;
			ovf        <= 1'b0;
			result     <= '0;
			result_rdy <= 1'b0;
		end else begin
			result_rdy <= s1_valid && s1_last; // 2 cycles after last beat
			if (s1_valid) begin
				acc  <= acc_next;
				peak <= peak_next;
				ovf  <= ovf_next;
			end
			if (s1_valid && s1_last) begin
				result.power    <= WORD_W'(acc_next >> POWER_SHIFT); // low 32 kept
				result.peak     <= peak_next;
				result.overflow <= ovf_next;
			end
		end
	end

endmodule

// ==== src/event_sequencer.sv ====
`timescale 1ns/1ns

module event_sequencer
	import bpm_pkg::*;
(
	input  logic                 clk,
	input  logic                 RST_EVENT_NO,
	input  logic                 start,
	input  logic                 sample_valid,
	input  adc_quad_t            sample,
	input  logic [EVT_LEN_W-1:0] evt_len,
	output beat_t                beat,
	output logic                 busy
);

	seq_state_e           state;
	logic [EVT_LEN_W-1:0] remaining;  // samples still to take
	logic                 first_pend; // next accepted sample is the first
	logic                 accept;
	logic                 last_smp;

	assign accept   = (state == SEQ_RUN) && sample_valid;
	assign last_smp = (remaining == EVT_LEN_W'(1));
	assign busy     = (state == SEQ_RUN); // state is registered so busy trails start by a cycle

	//////////////////////////////////////////////////////////////////////
	// event window
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			state      <= SEQ_IDLE;
			remaining  <= '0;
			first_pend <= 1'b0;
		end else begin
			case (state)
				SEQ_IDLE: if (start) begin // start only seen while idle
					state      <= SEQ_RUN;
					first_pend <= 1'b1;
					// short events stretched to the minimum
					remaining  <= (evt_len < EVT_LEN_W'(MIN_EVT_LEN)) ?
					              EVT_LEN_W'(MIN_EVT_LEN) : evt_len;
				end
				SEQ_RUN: if (sample_valid) begin
					remaining  <= remaining - 1'b1;
					first_pend <= 1'b0;
					if (last_smp)
						state <= SEQ_IDLE; // window closed
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// one cycle sample -> beat
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			beat <= '0;
		end else begin
			beat.valid <= accept;
			beat.first <= accept && first_pend;
			beat.last  <= accept && last_smp;
			beat.data  <= sample; // qualified by valid downstream
		end
	end

	// the clamp keeps first and last on separate beats
	a_last_closes: assert property (@(posedge clk) disable iff (RST_EVENT_NO)
		beat.last |-> beat.valid && !beat.first);

endmodule

// ==== src/bpm_pkg.sv ====
package bpm_pkg;

	//////////////////////////////////////////////////////////////////////
	// sizes and limits
	//////////////////////////////////////////////////////////////////////
	localparam int N_CH        = 4;   // channels a..d
	localparam int ADC_W       = 16;  // adc sample bits
	localparam int WORD_W      = 32;  // slow fifo word
	localparam int ACC_W       = 48;  // sum of squares
	localparam int EVT_LEN_W   = 16;  // evt_len register width
	localparam int CNT_W       = WORD_W / 2; // event counter, lower half of status word
	localparam int POWER_SHIFT = 10;
	localparam int MIN_EVT_LEN = 8;   // keeps results >= 8 cycles apart

	localparam int FIFO_DEPTH  = 32;
	localparam int FIFO_HALF   = 16;  // room check for a whole packet
	localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
	localparam int PACKET_LEN  = 8;   // words per event packet

	localparam logic [WORD_W-1:0] PID = 32'h4142_504d; // "ABPM"

	//////////////////////////////////////////////////////////////////////
	// data types
	//////////////////////////////////////////////////////////////////////
	typedef logic signed [ADC_W-1:0] adc_sample_t;
	typedef logic [ADC_W-1:0]        adc_mag_t;    // unsigned magnitude

	localparam adc_sample_t ADC_MAX = 16'sh7fff; // full scale, positive
	localparam adc_sample_t ADC_MIN = 16'sh8000; // full scale, negative

	// channel a sits in the low 16 bits, index 0 of the generate loop
	typedef struct packed {
		adc_sample_t d;
		adc_sample_t c;
		adc_sample_t b;
		adc_sample_t a;
	} adc_quad_t;

	typedef struct packed {
		logic      valid;
		logic      first; // first sample of the event
		logic      last;  // last sample of the event
		adc_quad_t data;
	} beat_t;

	typedef struct packed {
		logic [WORD_W-1:0] power;    // (sum x^2) >> POWER_SHIFT
		adc_mag_t          peak;     // largest |x|
		logic              overflow; // saw +/- full scale
	} chan_result_t;

	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [FIFO_PTR_W:0] fifo_count_t; // 0..32

	// sequencer state
	typedef enum logic {
		SEQ_IDLE,
		SEQ_RUN
	} seq_state_e;

	// packet slot being written, in packet order
	typedef enum logic [$clog2(PACKET_LEN+1)-1:0] {
		PKT_IDLE,
		PKT_PID,
		PKT_STATUS,
		PKT_PWR_A,
		PKT_PWR_B,
		PKT_PWR_C,
		PKT_PWR_D,
		PKT_PEAK_AB,
		PKT_PEAK_CD
	} pkt_word_e;

endpackage
